//--- hdl/color_pkg.sv
package color_pkg;

   localparam int DATA_W        = 32;
   localparam int ADDR_W        = 16;
   localparam int VERTEX_WORDS  = 4;
   localparam int NO_COLOR_FREE = 32;

   typedef enum logic [1:0] {
      ENQ            = 2'd0,
      SEND_DEGREE    = 2'd1,
      RECEIVE_DEGREE = 2'd2,
      RECEIVE_COLOR  = 2'd3
   } task_type_t;

   // enqueue view of the argument word
   typedef struct packed {
      logic [47:0] pad;
      logic [31:0] start;
   } enq_args_t;

   // per-vertex view with the chunk start in the low half-word
   typedef struct packed {
      logic [15:0] color;
      logic [31:0] sender;
      logic [15:0] degree;
      logic [15:0] chunk_start;
   } vertex_args_t;

   typedef union packed {
      enq_args_t    enq;
      vertex_args_t vtx;
   } task_args_u;

   typedef struct packed {
      task_type_t ttype;
      logic [31:0] locale;   // target vertex
      task_args_u  args;
   } task_t;

   // word 0 is the most significant field
   typedef struct packed {
      logic [31:0] eo_begin;
      logic [15:0] degrees_pending;
      logic [15:0] colors_pending;
      logic [31:0] scratch;   // neighbor color bitmap
      logic [15:0] degree;
      logic [15:0] color;
   } vertex_rec_t;

   typedef struct packed {
      task_t       tsk;
      logic [31:0] eo_begin;
      logic [15:0] degree;
   } fwd_task_t;

endpackage

//--- hdl/mem_bus_if.sv
`timescale 1ns/10ps

interface mem_bus_if;
   import color_pkg::*;

   logic              req;
   logic              we;
   logic [ADDR_W-1:0] addr;
   logic [DATA_W-1:0] wdata;
   logic              gnt;      // access completes this cycle
   logic              rvalid;   // pulses once per read
   logic [DATA_W-1:0] rdata;

   modport requester (
      output req, we, addr, wdata,
      input  gnt, rvalid, rdata
   );

   modport arbiter (
      input  req, we, addr, wdata,
      output gnt, rvalid, rdata
   );

endinterface

//--- hdl/mem_arbiter.sv
`timescale 1ns/10ps

module mem_arbiter (
   input  logic                         clk,
   input  logic                         rstn,
   mem_bus_if.arbiter                   peer_a,
   mem_bus_if.arbiter                   peer_b,
   output logic                         mem_req,
   output logic                         mem_we,
   output logic [color_pkg::ADDR_W-1:0] mem_addr,
   output logic [color_pkg::DATA_W-1:0] mem_wdata,
   input  logic                         mem_ready,
   input  logic                         mem_rvalid,
   input  logic [color_pkg::DATA_W-1:0] mem_rdata
);

   logic rd_pending;
   logic owner_b;   // issuer of the pending read
   logic prio_b;
   logic sel_b;
   logic accept;

   // b wins when alone or when it holds priority
   assign sel_b = peer_b.req && (!peer_a.req || prio_b);

   assign mem_req   = !rd_pending && (peer_a.req || peer_b.req);
   assign mem_we    = sel_b ? peer_b.we : peer_a.we;
   assign mem_addr  = sel_b ? peer_b.addr : peer_a.addr;
   assign mem_wdata = sel_b ? peer_b.wdata : peer_a.wdata;
   assign accept    = mem_req && mem_ready;

   assign peer_a.gnt = accept && !sel_b;
   assign peer_b.gnt = accept && sel_b;

   assign peer_a.rvalid = mem_rvalid && !owner_b;
   assign peer_b.rvalid = mem_rvalid && owner_b;
   assign peer_a.rdata  = mem_rdata;
   assign peer_b.rdata  = mem_rdata;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         rd_pending <= 1'b0;
         owner_b    <= 1'b0;
         prio_b     <= 1'b0;
      end else begin
         if (accept) begin
            prio_b <= !sel_b;   // other peer goes first next time
            if (!mem_we) begin
               rd_pending <= 1'b1;
               owner_b    <= sel_b;
            end
         end else if (mem_rvalid) begin
            rd_pending <= 1'b0;
         end
      end
   end

   a_one_grant : assert property (@(posedge clk) disable iff (!rstn)
      !(peer_a.gnt && peer_b.gnt));

   a_rvalid_pending : assert property (@(posedge clk) disable iff (!rstn)
      mem_rvalid |-> rd_pending);

endmodule

//--- hdl/vertex_update.sv
`timescale 1ns/10ps

module vertex_update (
   input  logic                         clk,
   input  logic                         rstn,
   input  logic                         task_in_valid,
   input  color_pkg::task_t             task_in,
   output logic                         task_in_ready,
   input  logic [color_pkg::ADDR_W-1:0] base_data,
   mem_bus_if.requester                 mem,
   output logic                         fwd_valid,
   output color_pkg::fwd_task_t         fwd_task,
   input  logic                         fwd_ready
);
   import color_pkg::*;

   typedef enum logic [2:0] {
      ST_IDLE, ST_RD_REQ, ST_RD_WAIT, ST_EVAL, ST_WR, ST_FWD
   } state_t;

   state_t state;
   task_t cur_task;
   logic [1:0] word_idx;   // four record words
   logic [VERTEX_WORDS-1:0][DATA_W-1:0] rd_words;
   logic [VERTEX_WORDS-1:0][DATA_W-1:0] upd_words;
   vertex_rec_t rec, upd;
   logic [ADDR_W-1:0] rec_addr;
   logic chunk0, higher, done;
   logic dp_inc, dp_dec, cp_inc, cp_dec;
   logic [15:0] dp_next, cp_next, pick;
   logic [31:0] new_scratch;
   logic do_write, do_fwd;
   task_t fwd_out;

   assign rec       = rd_words;
   assign upd_words = upd;
   assign rec_addr  = base_data + ADDR_W'(cur_task.locale * VERTEX_WORDS) + ADDR_W'(word_idx);

   assign chunk0 = (cur_task.args.vtx.chunk_start == 16'd0);
   assign higher = (cur_task.args.vtx.degree > rec.degree) ||
                   ((cur_task.args.vtx.degree == rec.degree) &&
                    (cur_task.args.vtx.sender < cur_task.locale));

   assign dp_inc = chunk0 && (cur_task.ttype == SEND_DEGREE);
   assign dp_dec = chunk0 && (cur_task.ttype == RECEIVE_DEGREE);
   assign cp_inc = dp_dec && higher;
   assign cp_dec = chunk0 && (cur_task.ttype == RECEIVE_COLOR) && higher;

   assign dp_next = dp_inc ? rec.degrees_pending + rec.degree :
                    dp_dec ? rec.degrees_pending - 16'd1 : rec.degrees_pending;
   assign cp_next = cp_inc ? rec.colors_pending + 16'd1 :
                    cp_dec ? rec.colors_pending - 16'd1 : rec.colors_pending;
   assign new_scratch = cp_dec ? (rec.scratch | (32'd1 << cur_task.args.vtx.color[4:0])) :
                        rec.scratch;
   assign done = (dp_next == 16'd0) && (cp_next == 16'd0);

   // lowest clear bitmap bit
   always_comb begin
      pick = 16'(NO_COLOR_FREE);
      for (int i = 31; i >= 0; i--) begin
         if (!new_scratch[i]) pick = 16'(i);
      end
   end

   always_comb begin
      upd = rec;
      upd.degrees_pending = dp_next;
      upd.colors_pending  = cp_next;
      upd.scratch         = new_scratch;
      do_write = dp_inc || dp_dec || cp_dec;
      do_fwd   = 1'b0;
      fwd_out  = cur_task;
      case (cur_task.ttype)
         ENQ: do_fwd = 1'b1;
         SEND_DEGREE: begin
            fwd_out.args.vtx.degree = rec.degree;
            do_fwd = 1'b1;
         end
         default: begin
            // continuations (chunk start != 0) pass through once colored
            do_fwd = done && (cur_task.ttype == RECEIVE_DEGREE || cp_dec || !chunk0);
            if (do_fwd) begin
               upd.color = pick;
               fwd_out.args.vtx.color  = pick;
               fwd_out.args.vtx.degree = rec.degree;
            end
         end
      endcase
   end

   assign task_in_ready = (state == ST_IDLE);
   assign mem.req   = (state == ST_RD_REQ) || (state == ST_WR);
   assign mem.we    = (state == ST_WR);
   assign mem.addr  = rec_addr;
   assign mem.wdata = upd_words[2'd3 - word_idx];

   assign fwd_valid = (state == ST_FWD);
   assign fwd_task  = '{tsk: fwd_out, eo_begin: rec.eo_begin, degree: rec.degree};

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state    <= ST_IDLE;
         word_idx <= 2'd0;
      end else begin
         case (state)
            ST_IDLE: if (task_in_valid) begin
               word_idx <= 2'd0;
               state    <= (task_in.ttype == ENQ) ? ST_FWD : ST_RD_REQ;
            end
            ST_RD_REQ: if (mem.gnt) state <= ST_RD_WAIT;
            ST_RD_WAIT: if (mem.rvalid) begin
               word_idx <= word_idx + 2'd1;   // wraps to 0 after word 3
               state    <= (word_idx == 2'd3) ? ST_EVAL : ST_RD_REQ;
            end
            ST_EVAL: state <= do_write ? ST_WR : (do_fwd ? ST_FWD : ST_IDLE);
            ST_WR: if (mem.gnt) begin
               word_idx <= word_idx + 2'd1;
               if (word_idx == 2'd3) state <= do_fwd ? ST_FWD : ST_IDLE;
            end
            ST_FWD: if (fwd_ready) state <= ST_IDLE;
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == ST_IDLE && task_in_valid) cur_task <= task_in;
      if (state == ST_RD_WAIT && mem.rvalid) rd_words[2'd3 - word_idx] <= mem.rdata;
   end

   a_no_underflow : assert property (@(posedge clk) disable iff (!rstn)
      (state == ST_WR) |->
         !(dp_dec && rec.degrees_pending == 16'd0) && !(cp_dec && rec.colors_pending == 16'd0));

endmodule

//--- hdl/neighbor_expander.sv
`timescale 1ns/10ps

module neighbor_expander (
   input  logic                         clk,
   input  logic                         rstn,
   input  logic                         fwd_valid,
   input  color_pkg::fwd_task_t         fwd_task,
   output logic                         fwd_ready,
   input  logic [31:0]                  num_v,
   input  logic [color_pkg::ADDR_W-1:0] base_neighbors,
   input  logic [6:0]                   enq_limit,
   mem_bus_if.requester                 mem,
   output logic                         task_out_valid,
   output color_pkg::task_t             task_out,
   input  logic                         task_out_ready
);
   import color_pkg::*;

   typedef enum logic [2:0] {
      ST_IDLE, ST_RD_REQ, ST_RD_WAIT, ST_EMIT, ST_CONT
   } state_t;

   state_t state;
   fwd_task_t cur;
   logic [31:0] idx, end_r, next_r, nbr;
   logic more_r;
   logic in_enq, cur_enq;
   logic [31:0] span_start, span_lim, span_sum, span_end;

   assign in_enq  = (fwd_task.tsk.ttype == ENQ);
   assign cur_enq = (cur.tsk.ttype == ENQ);

   // vertex range for ENQ, neighbor range otherwise
   assign span_start = in_enq ? fwd_task.tsk.args.enq.start :
                                {16'd0, fwd_task.tsk.args.vtx.chunk_start};
   assign span_lim   = in_enq ? num_v : {16'd0, fwd_task.degree};
   assign span_sum   = span_start + {25'd0, enq_limit};
   assign span_end   = (span_sum > span_lim) ? span_lim : span_sum;

   assign fwd_ready = (state == ST_IDLE);
   assign mem.req   = (state == ST_RD_REQ);
   assign mem.we    = 1'b0;
   assign mem.addr  = base_neighbors + ADDR_W'(cur.eo_begin + idx);
   assign mem.wdata = '0;

   assign task_out_valid = (state == ST_EMIT) || (state == ST_CONT);

   always_comb begin
      task_out = cur.tsk;
      if (state == ST_CONT) begin
         if (cur_enq) begin
            task_out.locale = next_r;
            task_out.args = '0;
            task_out.args.enq.start = next_r;
         end else begin
            task_out.args.vtx.chunk_start = next_r[15:0];
         end
      end else if (cur_enq) begin
         task_out.ttype  = SEND_DEGREE;
         task_out.locale = idx;
         task_out.args   = '0;
      end else begin
         task_out.ttype  = (cur.tsk.ttype == SEND_DEGREE) ? RECEIVE_DEGREE : RECEIVE_COLOR;
         task_out.locale = nbr;
         task_out.args   = '0;
         task_out.args.vtx.degree = cur.degree;
         task_out.args.vtx.sender = cur.tsk.locale;
         if (cur.tsk.ttype != SEND_DEGREE) task_out.args.vtx.color = cur.tsk.args.vtx.color;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE: if (fwd_valid) begin
               if (span_start >= span_end) state <= ST_IDLE;   // nothing left
               else state <= in_enq ? ST_EMIT : ST_RD_REQ;
            end
            ST_RD_REQ: if (mem.gnt) state <= ST_RD_WAIT;
            ST_RD_WAIT: if (mem.rvalid) state <= ST_EMIT;
            ST_EMIT: if (task_out_ready) begin
               if (idx + 32'd1 == end_r) state <= more_r ? ST_CONT : ST_IDLE;
               else state <= cur_enq ? ST_EMIT : ST_RD_REQ;
            end
            ST_CONT: if (task_out_ready) state <= ST_IDLE;
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == ST_IDLE && fwd_valid) begin
         cur    <= fwd_task;
         idx    <= span_start;
         end_r  <= span_end;
         next_r <= span_sum;
         more_r <= (span_sum < span_lim);
      end
      if (state == ST_RD_WAIT && mem.rvalid) nbr <= mem.rdata;
      if (state == ST_EMIT && task_out_ready) idx <= idx + 32'd1;
   end

   a_out_stable : assert property (@(posedge clk) disable iff (!rstn)
      task_out_valid && !task_out_ready |=> task_out_valid && $stable(task_out));

endmodule

//--- hdl/color_tile.sv
`timescale 1ns/10ps

module color_tile (
   input  logic                         clk,
   input  logic                         rstn,
   input  logic                         task_in_valid,
   input  color_pkg::task_t             task_in,
   output logic                         task_in_ready,
   output logic                         task_out_valid,
   output color_pkg::task_t             task_out,
   input  logic                         task_out_ready,
   input  logic [31:0]                  num_v,
   input  logic [color_pkg::ADDR_W-1:0] base_data,
   input  logic [color_pkg::ADDR_W-1:0] base_neighbors,
   input  logic [6:0]                   enq_limit,
   output logic                         mem_req,
   output logic                         mem_we,
   output logic [color_pkg::ADDR_W-1:0] mem_addr,
   output logic [color_pkg::DATA_W-1:0] mem_wdata,
   input  logic                         mem_ready,
   input  logic                         mem_rvalid,
   input  logic [color_pkg::DATA_W-1:0] mem_rdata
);
   import color_pkg::*;

   logic      fwd_valid;
   logic      fwd_ready;
   fwd_task_t fwd_task;

   mem_bus_if upd_bus ();
   mem_bus_if exp_bus ();

   mem_arbiter mem_arbiter_inst (
      .clk        (clk),
      .rstn       (rstn),
      .peer_a     (upd_bus.arbiter),
      .peer_b     (exp_bus.arbiter),
      .mem_req    (mem_req),
      .mem_we     (mem_we),
      .mem_addr   (mem_addr),
      .mem_wdata  (mem_wdata),
      .mem_ready  (mem_ready),
      .mem_rvalid (mem_rvalid),
      .mem_rdata  (mem_rdata)
   );

   vertex_update vertex_update_inst (
      .clk           (clk),
      .rstn          (rstn),
      .task_in_valid (task_in_valid),
      .task_in       (task_in),
      .task_in_ready (task_in_ready),
      .base_data     (base_data),
      .mem           (upd_bus.requester),
      .fwd_valid     (fwd_valid),
      .fwd_task      (fwd_task),
      .fwd_ready     (fwd_ready)
   );

   neighbor_expander neighbor_expander_inst (
      .clk            (clk),
      .rstn           (rstn),
      .fwd_valid      (fwd_valid),
      .fwd_task       (fwd_task),
      .fwd_ready      (fwd_ready),
      .num_v          (num_v),
      .base_neighbors (base_neighbors),
      .enq_limit      (enq_limit),
      .mem            (exp_bus.requester),
      .task_out_valid (task_out_valid),
      .task_out       (task_out),
      .task_out_ready (task_out_ready)
   );

endmodule

//--- dv/color_checker.sv
`timescale 1ns/10ps

module color_checker (
   input  logic                         clk,
   input  logic                         rstn,
   input  logic                         task_out_valid,
   input  color_pkg::task_t             task_out,
   input  logic                         task_out_ready,
   input  logic                         mem_req,
   input  logic                         mem_ready,
   input  logic                         mem_we,
   input  logic [color_pkg::ADDR_W-1:0] mem_addr,
   input  logic [color_pkg::DATA_W-1:0] mem_wdata,
   input  logic                         final_check,
   output int                           seen,
   output int                           out_errors,
   output int                           color_errors
);
   import color_pkg::*;

   logic [31:0] cases [0:255];
   logic [31:0] recs [0:15];   // shadow of the written vertex records
   logic        wr_changed;    // current record write differs from the shadow

   initial begin
      for (int i = 0; i < 256; i++) cases[i] = 32'd0;
      $readmemh("dv/color_cases.txt", cases);
   end

   function automatic string test_name(int n);
      case (n)
         1: return "enq_spread";
         2: return "send_degree_chunks";
         3: return "receive_degree_done";
         4: return "receive_color";
         5: return "full_bitmap";
         default: return "unknown";
      endcase
   endfunction

   function automatic task_t expected_task(int idx);
      int b;
      b = 'h80 + 4 * idx;
      return {cases[b][17:16], cases[b+1], cases[b][15:0], cases[b+2], cases[b+3]};
   endfunction

   always @(posedge clk) begin
      task_t exp_t;
      int off;
      if (!rstn) begin
         seen       = 0;
         out_errors = 0;
         wr_changed = 1'b0;
         for (int w = 0; w < 16; w++) recs[w] = cases['h10 + w];
      end else begin
         if (task_out_valid && task_out_ready) begin
            if (seen >= int'(cases[5])) begin
               out_errors++;
               $display("unexpected extra output task %h after the expected list", task_out);
            end else begin
               exp_t = expected_task(seen);
               if (task_out !== exp_t) begin
                  out_errors++;
                  $display("ERROR %s: output %0d expected %h actual %h",
                           test_name(int'(cases['h80 + 4 * seen][31:24])), seen, exp_t, task_out);
               end
            end
            seen++;
         end
         if (mem_req && mem_ready && mem_we) begin
            off = int'(mem_addr) - int'(cases[1]);
            if (off >= 0 && off < 16) begin
               if (recs[off] !== mem_wdata) wr_changed = 1'b1;
               recs[off] = mem_wdata;
               if ((off % 4) == 3) begin
                  if (!wr_changed) begin
                     out_errors++;
                     $display("record write to vertex %0d left the record unchanged", off / 4);
                  end
                  wr_changed = 1'b0;
               end
            end
         end
      end
   end

   always @(posedge final_check) begin
      int cnt;
      cnt = 0;
      for (int v = 0; v < 4; v++) begin
         if (recs[4 * v + 3][15:0] !== cases['hf0 + v][15:0]) begin
            cnt++;
            $display("ERROR final_colors: vertex %0d expected %0d actual %0d",
                     v, cases['hf0 + v][15:0], recs[4 * v + 3][15:0]);
         end
      end
      color_errors = cnt;
   end

endmodule

//--- dv/color_tile_tb.sv
`timescale 1ns/10ps

module color_tile_tb;
   import color_pkg::*;

   logic              clk = 1'b0;
   logic              rstn;
   logic              task_in_valid;
   task_t             task_in;
   logic              task_in_ready;
   logic              task_out_valid;
   task_t             task_out;
   logic              task_out_ready = 1'b0;
   logic [31:0]       num_v;
   logic [ADDR_W-1:0] base_data;
   logic [ADDR_W-1:0] base_neighbors;
   logic [6:0]        enq_limit;
   logic              mem_req;
   logic              mem_we;
   logic [ADDR_W-1:0] mem_addr;
   logic [DATA_W-1:0] mem_wdata;
   logic              mem_ready = 1'b0;
   logic              mem_rvalid = 1'b0;
   logic [DATA_W-1:0] mem_rdata = '0;

   logic [31:0] cases [0:255];
   logic [31:0] mem [0:63];
   integer      seed = 32'h9952a1c1;
   int          n_in;
   int          n_exp;
   int          rd_issue = 0;   // bumped per accepted read
   int          rd_seen = 0;
   int          rd_cnt = 0;
   logic        rd_busy = 1'b0;
   logic [5:0]  rd_addr = '0;
   logic        final_check;
   int          seen;
   int          out_errors;
   int          color_errors;

   always #50 clk = ~clk;

   color_tile color_tile_inst (.*);

   color_checker color_checker_inst (
      .clk (clk), .rstn (rstn),
      .task_out_valid (task_out_valid), .task_out (task_out), .task_out_ready (task_out_ready),
      .mem_req (mem_req), .mem_ready (mem_ready), .mem_we (mem_we),
      .mem_addr (mem_addr), .mem_wdata (mem_wdata),
      .final_check (final_check), .seen (seen),
      .out_errors (out_errors), .color_errors (color_errors)
   );

   function automatic task_t words_to_task(int b);
      return {cases[b][17:16], cases[b+1], cases[b][15:0], cases[b+2], cases[b+3]};
   endfunction

   // memory accepts on the rising edge
   always @(posedge clk) begin
      if (!rstn) begin
         for (int a = 0; a < 64; a++) mem[a] = (a < 48) ? cases['h10 + a] : 32'd0;
      end else if (mem_req && mem_ready) begin
         if (mem_we) begin
            mem[mem_addr[5:0]] = mem_wdata;
         end else begin
            rd_addr  = mem_addr[5:0];
            rd_issue = rd_issue + 1;
         end
      end
   end

   // read return after 1 to 4 cycles with random stalls
   always @(negedge clk) begin
      mem_rvalid = 1'b0;
      if (rd_issue != rd_seen) begin
         rd_seen = rd_issue;
         rd_busy = 1'b1;
         rd_cnt  = $random(seed) & 3;
      end else if (rd_busy) begin
         rd_cnt = rd_cnt - 1;
      end
      if (rd_busy && rd_cnt == 0) begin
         mem_rvalid = 1'b1;
         mem_rdata  = mem[rd_addr];
         rd_busy    = 1'b0;
      end
      mem_ready      = ($random(seed) & 3) != 0;
      task_out_ready = ($random(seed) & 3) != 0;
   end

   initial begin
      rstn           = 1'b0;
      task_in_valid  = 1'b0;
      task_in        = '0;
      final_check    = 1'b0;
      num_v          = '0;
      base_data      = '0;
      base_neighbors = '0;
      enq_limit      = '0;
      for (int i = 0; i < 256; i++) cases[i] = 32'd0;
      $readmemh("dv/color_cases.txt", cases);
      num_v          = cases[0];
      base_data      = cases[1][ADDR_W-1:0];
      base_neighbors = cases[2][ADDR_W-1:0];
      enq_limit      = cases[3][6:0];
      n_in           = int'(cases[4]);
      n_exp          = int'(cases[5]);
      repeat (8) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;
      for (int i = 0; i < n_in; i++) begin
         task_in_valid = 1'b1;
         task_in       = words_to_task('h40 + 4 * i);
         while (!task_in_ready) @(negedge clk);
         @(negedge clk);   // taken on the edge just passed
      end
      task_in_valid = 1'b0;
      task_in       = '0;
      while (seen < n_exp) @(negedge clk);
      repeat (20) @(negedge clk);   // catch stray outputs
      final_check = 1'b1;
      @(negedge clk);
      $display("closing: %0d output errors, %0d color errors", out_errors, color_errors);
      if (out_errors == 0 && color_errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

   initial begin
      int limit;
      #1;
      limit = int'(cases[4] + cases[5]) * 200;
      repeat (limit) @(posedge clk);
      $display("timeout: the DUT did not deliver all %0d output tasks within %0d cycles",
               n_exp, limit);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

//--- build.f
hdl/color_pkg.sv
hdl/mem_bus_if.sv
hdl/mem_arbiter.sv
hdl/vertex_update.sv
hdl/neighbor_expander.sv
hdl/color_tile.sv
dv/color_checker.sv
dv/color_tile_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the color_tile testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module color_tile_tb \
   --Mdir obj_dir -o color_tile_sim > build.log 2>&1
if [ $? -ne 0 ]; then
   echo "compile failed, see build.log"
   exit 1
fi

./obj_dir/color_tile_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
   exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
   echo "no pass line found in sim.log"
   exit 1
fi
exit 0

//--- dv/color_cases.txt
// word layout per task: {test[31:24], type[17:16], color[15:0]} locale sender {degree, chunk}
// @00 config: num_v base_data base_neighbors enq_limit inputs outputs vertices
@00 00000004 00000000 00000020 00000002 0000000d 00000010 00000004
// @10 memory image, record words: eo_begin {dpend, cpend} bitmap {degree, color}
@10 00000000 00000000 00000000 00030000
00000003 00000000 00000000 00020000
00000005 00000000 00000000 00020000
00000007 00000001 7fffffff 00010000
// neighbor lists from memory word 0x20
@30 00000001 00000002 00000003 00000000 00000002 00000000 00000001 00000000
// @40 input tasks
@40 01000000 00000000 00000000 00000000
02010000 00000000 00000000 00000000
02010000 00000000 00000000 00030002
03010000 00000001 00000000 00000000
03020000 00000001 00000000 00030000
03020000 00000001 00000002 00020000
03020000 00000000 00000001 00020000
03020000 00000000 00000002 00020000
03020000 00000000 00000003 00010000
03020000 00000000 00000003 00030002
04030000 00000001 00000000 00030000
04030001 00000000 00000001 00020000
0503001f 00000003 00000000 00030000
// @80 expected output tasks in order
@80 01010000 00000000 00000000 00000000
01010000 00000001 00000000 00000000
01000000 00000002 00000000 00000002
02020000 00000001 00000000 00030000
02020000 00000002 00000000 00030000
02010000 00000000 00000000 00030002
02020000 00000003 00000000 00030000
03020000 00000000 00000001 00020000
03020000 00000002 00000001 00020000
03030000 00000001 00000000 00030000
03030000 00000002 00000000 00030000
03020000 00000000 00000003 00030002
03030000 00000003 00000000 00030000
04030001 00000000 00000001 00020000
04030001 00000002 00000001 00020000
05030020 00000000 00000003 00010000
// @f0 expected final color per vertex
@f0 00000000 00000001 00000000 00000020
